/* include/ram_writer_params.svh */
`ifndef RAM_WRITER_PARAMS_SVH
`define RAM_WRITER_PARAMS_SVH

// AXI3 write master widths
`define RW_ID_WIDTH        6
`define RW_ADDR_WIDTH      32
`define RW_DATA_WIDTH      64

// Input stream
`define RW_SAMPLE_WIDTH    32

// Recording window in external memory
`define RW_ADDR_BASE       32'h1E000000
`define RW_WINDOW_BITS     10           // Word counter width, 1024 words

// Burst shape is fixed by the 4-bit AXI3 awlen
`define RW_BURST_BEATS     16

// Buffering and flow limits
`define RW_FIFO_DEPTH      32           // Power of two
`define RW_MAX_OUTSTANDING 4

`endif

/* source/axi_wr_pkg.sv */
`include "ram_writer_params.svh"

package axi_wr_pkg;

  typedef enum logic [1:0]
  {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0]
  {
    WR_IDLE,                                     // Waiting for a full burst in the FIFO
    WR_ADDR,                                     // AW valid
    WR_DATA                                      // W beats in flight
  } wr_state_e;

  typedef struct packed
  {
    logic [`RW_ID_WIDTH-1:0]   id;
    logic [`RW_ADDR_WIDTH-1:0] addr;
    logic [3:0]                len;              // Beats minus one
    logic [2:0]                size;             // Log2 of bytes per beat
    logic [1:0]                burst;
    logic [3:0]                cache;
  } axi_aw_t;

  typedef struct packed
  {
    logic [`RW_ID_WIDTH-1:0]     id;             // AXI3 only
    logic [`RW_DATA_WIDTH-1:0]   data;
    logic [`RW_DATA_WIDTH/8-1:0] strb;
    logic                        last;
  } axi_w_t;

  typedef struct packed
  {
    logic [`RW_ID_WIDTH-1:0] id;
    axi_resp_e               resp;
  } axi_b_t;

endpackage

/* source/stream_pkg.sv */
`include "ram_writer_params.svh"

package stream_pkg;

  // First sample of a pair lands in the low half
  typedef struct packed
  {
    logic [`RW_SAMPLE_WIDTH-1:0] hi;
    logic [`RW_SAMPLE_WIDTH-1:0] lo;
  } mem_word_t;

  typedef enum logic
  {
    PACK_LOW,
    PACK_HIGH
  } pack_state_e;

  typedef struct packed
  {
    logic [15:0] bursts_issued;                  // AW handshakes
    logic [15:0] bursts_done;                    // B handshakes
    logic [2:0]  outstanding;
    logic        error;                          // Sticky
  } rec_status_t;

endpackage

/* source/sample_packer.sv */
`timescale 1ns/100ps
`include "ram_writer_params.svh"

module sample_packer
(
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic [`RW_SAMPLE_WIDTH-1:0] s_axis_tdata,
  input  logic                        s_axis_tvalid,
  output logic                        s_axis_tready,
  input  logic                        full,
  output logic                        push,
  output stream_pkg::mem_word_t       push_word
);

  stream_pkg::pack_state_e     state;
  logic                        pending;          // Word complete but not yet in the FIFO
  logic [`RW_SAMPLE_WIDTH-1:0] lo_sample;
  logic                        take;

  assign s_axis_tready = !(full && pending);     // Stall only when the held word can't drain
  assign take          = s_axis_tvalid && s_axis_tready;
  assign push          = pending && !full;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state   <= stream_pkg::PACK_LOW;
      pending <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        pending <= 1'b0;
      end
      if (take)
      begin
        if (state == stream_pkg::PACK_LOW)
        begin
          state <= stream_pkg::PACK_HIGH;
        end
        else
        begin
          state   <= stream_pkg::PACK_LOW;
          pending <= 1'b1;                       // Overrides the drain above
        end
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (take && state == stream_pkg::PACK_LOW)
    begin
      lo_sample <= s_axis_tdata;
    end
    if (take && state == stream_pkg::PACK_HIGH)
    begin
      push_word.lo <= lo_sample;
      push_word.hi <= s_axis_tdata;
    end
  end

  // A refused sample must stay on the stream until it is taken
  sample_held: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid && $stable(s_axis_tdata))
    else $error("sample_packer: stream sample changed before tready");

endmodule

/* source/beat_fifo.sv */
`timescale 1ns/100ps
`include "ram_writer_params.svh"

module beat_fifo
(
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic                                push,
  input  stream_pkg::mem_word_t               push_word,
  output logic                                full,
  input  logic                                pop,
  output stream_pkg::mem_word_t               pop_word,
  output logic [$clog2(`RW_FIFO_DEPTH):0]     count
);

  localparam int DEPTH = `RW_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  stream_pkg::mem_word_t mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;                 // Wraps naturally at DEPTH
  logic [PTR_W-1:0]      rd_ptr;

  assign full     = (count == (PTR_W+1)'(DEPTH));
  assign pop_word = mem[rd_ptr];                 // Head is readable without a pop

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= push_word;
    end
  end

  no_pop_empty: assert property (@(posedge aclk) disable iff (!aresetn)
    pop |-> count != '0)
    else $error("beat_fifo: pop while empty");

  no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
    push |-> !full)
    else $error("beat_fifo: push while full");

endmodule

/* source/burst_writer.sv */
`timescale 1ns/100ps
`include "ram_writer_params.svh"

module burst_writer
(
  input  logic                            aclk,
  input  logic                            aresetn,
  input  stream_pkg::mem_word_t           pop_word,
  input  logic [$clog2(`RW_FIFO_DEPTH):0] count,
  output logic                            pop,
  input  logic                            may_issue,
  output logic                            burst_sent,
  output axi_wr_pkg::axi_aw_t             m_axi_aw,
  output logic                            m_axi_awvalid,
  input  logic                            m_axi_awready,
  output axi_wr_pkg::axi_w_t              m_axi_w,
  output logic                            m_axi_wvalid,
  input  logic                            m_axi_wready
);

  localparam int CNT_W     = $clog2(`RW_FIFO_DEPTH) + 1;
  localparam int BEAT_BITS = $clog2(`RW_BURST_BEATS);
  localparam int SIZE      = $clog2(`RW_DATA_WIDTH / 8);

  axi_wr_pkg::wr_state_e      state;
  logic [`RW_WINDOW_BITS-1:0] word_cnt;          // Word offset into the window
  logic [`RW_ID_WIDTH-1:0]    burst_id;
  logic                       beat_last;
  logic                       burst_ready;

  assign beat_last   = &word_cnt[BEAT_BITS-1:0];
  assign burst_ready = (count >= CNT_W'(`RW_BURST_BEATS)) && may_issue;

  assign m_axi_awvalid = (state == axi_wr_pkg::WR_ADDR);
  assign m_axi_wvalid  = (state == axi_wr_pkg::WR_DATA);
  assign burst_sent    = m_axi_awvalid && m_axi_awready;
  assign pop           = m_axi_wvalid && m_axi_wready;

  always_comb
  begin
    m_axi_aw.id    = burst_id;
    m_axi_aw.addr  = `RW_ADDR_BASE + {word_cnt, SIZE'(0)};  // Byte address of first beat
    m_axi_aw.len   = 4'(`RW_BURST_BEATS - 1);
    m_axi_aw.size  = 3'(SIZE);
    m_axi_aw.burst = 2'b01;                      // INCR
    m_axi_aw.cache = 4'b0001;                    // Bufferable

    m_axi_w.id     = burst_id;
    m_axi_w.data   = pop_word;
    m_axi_w.strb   = '1;
    m_axi_w.last   = beat_last;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state    <= axi_wr_pkg::WR_IDLE;
      word_cnt <= '0;
      burst_id <= '0;
    end
    else
    begin
      case (state)
        axi_wr_pkg::WR_IDLE:
        begin
          if (burst_ready)
          begin
            state <= axi_wr_pkg::WR_ADDR;
          end
        end
        axi_wr_pkg::WR_ADDR:
        begin
          if (m_axi_awready)
          begin
            state <= axi_wr_pkg::WR_DATA;
          end
        end
        axi_wr_pkg::WR_DATA:
        begin
          if (m_axi_wready)
          begin
            word_cnt <= word_cnt + 1'b1;         // Wraps at the window end
            if (beat_last)
            begin
              burst_id <= burst_id + 1'b1;
              state    <= axi_wr_pkg::WR_IDLE;
            end
          end
        end
        default: state <= axi_wr_pkg::WR_IDLE;
      endcase
    end
  end

  aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_aw))
    else $error("burst_writer: AW changed before awready");

endmodule

/* source/write_response_tracker.sv */
`timescale 1ns/100ps
`include "ram_writer_params.svh"

module write_response_tracker
(
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    burst_sent,
  input  axi_wr_pkg::axi_b_t      m_axi_b,
  input  logic                    m_axi_bvalid,
  output logic                    m_axi_bready,
  output logic                    may_issue,
  output stream_pkg::rec_status_t status
);

  logic [15:0] issued;
  logic [15:0] done;
  logic [2:0]  outstanding;                      // Bursts awaiting B
  logic        error_q;
  logic        b_fire;

  assign m_axi_bready = 1'b1;                    // Responses are never stalled
  assign b_fire       = m_axi_bvalid && m_axi_bready;
  assign may_issue    = outstanding < 3'(`RW_MAX_OUTSTANDING);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      issued      <= '0;
      done        <= '0;
      outstanding <= '0;
      error_q     <= 1'b0;
    end
    else
    begin
      issued <= issued + 16'(burst_sent);
      done   <= done + 16'(b_fire);
      case ({burst_sent, b_fire})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
      if (b_fire && m_axi_b.resp != axi_wr_pkg::RESP_OKAY)
      begin
        error_q <= 1'b1;
      end
    end
  end

  always_comb
  begin
    status.bursts_issued = issued;
    status.bursts_done   = done;
    status.outstanding   = outstanding;
    status.error         = error_q;
  end

  // Slave must not answer a burst the writer never addressed
  b_has_owner: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axi_bvalid |-> outstanding != 3'd0)
    else $error("write_response_tracker: B with no outstanding burst");

endmodule

/* source/axis_ram_writer_top.sv */
`timescale 1ns/100ps
`include "ram_writer_params.svh"

module axis_ram_writer_top
(
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic [`RW_SAMPLE_WIDTH-1:0] s_axis_tdata,
  input  logic                        s_axis_tvalid,
  output logic                        s_axis_tready,
  output axi_wr_pkg::axi_aw_t         m_axi_aw,
  output logic                        m_axi_awvalid,
  input  logic                        m_axi_awready,
  output axi_wr_pkg::axi_w_t          m_axi_w,
  output logic                        m_axi_wvalid,
  input  logic                        m_axi_wready,
  input  axi_wr_pkg::axi_b_t          m_axi_b,
  input  logic                        m_axi_bvalid,
  output logic                        m_axi_bready,
  output stream_pkg::rec_status_t     status
);

  logic                            push;
  stream_pkg::mem_word_t           push_word;
  logic                            full;
  logic                            pop;
  stream_pkg::mem_word_t           pop_word;
  logic [$clog2(`RW_FIFO_DEPTH):0] count;
  logic                            burst_sent;
  logic                            may_issue;

  sample_packer u_packer
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .full          (full),
    .push          (push),
    .push_word     (push_word)
  );

  beat_fifo u_fifo
  (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (push),
    .push_word (push_word),
    .full      (full),
    .pop       (pop),
    .pop_word  (pop_word),
    .count     (count)
  );

  burst_writer u_writer
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .pop_word      (pop_word),
    .count         (count),
    .pop           (pop),
    .may_issue     (may_issue),
    .burst_sent    (burst_sent),
    .m_axi_aw      (m_axi_aw),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_w       (m_axi_w),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready)
  );

  write_response_tracker u_tracker
  (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .burst_sent   (burst_sent),
    .m_axi_b      (m_axi_b),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .may_issue    (may_issue),
    .status       (status)
  );

endmodule

/* verif/axi_mem_slave.sv */
`timescale 1ns/100ps
`include "ram_writer_params.svh"

module axi_mem_slave
#(
  parameter int ERR_BURST = 37,                  // Burst number answered with SLVERR
  parameter int B_DELAY   = 250                  // Cycles from last beat to B
)
(
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                hold_w,            // Forces wready low
  input  axi_wr_pkg::axi_aw_t aw,
  input  logic                awvalid,
  output logic                awready,
  input  axi_wr_pkg::axi_w_t  w,
  input  logic                wvalid,
  output logic                wready,
  output axi_wr_pkg::axi_b_t  b,
  output logic                bvalid,
  input  logic                bready
);

  localparam int WIN_WORDS = 1 << `RW_WINDOW_BITS;

  logic [`RW_DATA_WIDTH-1:0]  mem [WIN_WORDS];
  logic [`RW_WINDOW_BITS-1:0] wr_idx;            // Next word of the current burst
  logic [31:0]                rng_state;
  int                         cycle;
  int                         bursts_seen;
  logic [`RW_ID_WIDTH-1:0]    resp_id [$];       // Completed bursts awaiting B
  int                         resp_due [$];
  int                         resp_num [$];

  // Halves swapped so the low bits are not the short-period LCG bits
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {rng_state[15:0], rng_state[31:16]};
  endfunction

  initial
  begin
    rng_state = 32'd46;
    awready   = 1'b0;
    wready    = 1'b0;
    bvalid    = 1'b0;
    b         = '0;
  end

  always @(posedge aclk)
  begin
    cycle <= cycle + 1;
    if (!aresetn)
    begin
      awready     <= 1'b0;
      wready      <= 1'b0;
      bvalid      <= 1'b0;
      bursts_seen = 0;
    end
    else
    begin
      awready <= (next_rand() % 4) != 0;
      wready  <= !hold_w && ((next_rand() % 4) != 0);
      if (awvalid && awready)
      begin
        wr_idx <= `RW_WINDOW_BITS'((aw.addr - `RW_ADDR_BASE) >> 3);
      end
      if (wvalid && wready)
      begin
        mem[wr_idx] <= w.data;
        wr_idx      <= wr_idx + 1'b1;
        if (w.last)
        begin
          resp_id.push_back(w.id);
          resp_due.push_back(cycle + B_DELAY);
          resp_num.push_back(bursts_seen);
          bursts_seen++;
        end
      end
      if (bvalid && bready)
      begin
        bvalid <= 1'b0;
      end
      else if (!bvalid && resp_due.size() > 0 && cycle >= resp_due[0])
      begin
        bvalid <= 1'b1;
        b.id   <= resp_id.pop_front();
        b.resp <= (resp_num.pop_front() == ERR_BURST) ? axi_wr_pkg::RESP_SLVERR
                                                      : axi_wr_pkg::RESP_OKAY;
        void'(resp_due.pop_front());
      end
    end
  end

endmodule

/* verif/tb_axis_ram_writer.sv */
`timescale 1ns/100ps
`include "ram_writer_params.svh"

module tb_axis_ram_writer;

  localparam int NUM_SAMPLES    = 2560;
  localparam int NUM_BURSTS     = NUM_SAMPLES / (2 * `RW_BURST_BEATS);
  localparam int MAX_CYCLES     = 20 * NUM_SAMPLES;
  localparam int HOLD_START     = 1500;          // Long wready stall window
  localparam int HOLD_END       = 1800;
  localparam int WIN_WORDS      = 1 << `RW_WINDOW_BITS;
  localparam int BURSTS_PER_WIN = WIN_WORDS / `RW_BURST_BEATS;
  localparam int ID_MOD         = 1 << `RW_ID_WIDTH;

  logic                        aclk;
  logic                        aresetn;
  logic [`RW_SAMPLE_WIDTH-1:0] s_axis_tdata;
  logic                        s_axis_tvalid;
  logic                        s_axis_tready;
  axi_wr_pkg::axi_aw_t         m_axi_aw;
  logic                        m_axi_awvalid;
  logic                        m_axi_awready;
  axi_wr_pkg::axi_w_t          m_axi_w;
  logic                        m_axi_wvalid;
  logic                        m_axi_wready;
  axi_wr_pkg::axi_b_t          m_axi_b;
  logic                        m_axi_bvalid;
  logic                        m_axi_bready;
  stream_pkg::rec_status_t     status;
  logic                        hold_w;

  logic [31:0]                 rng_state;
  logic [63:0]                 exp_words [$];    // Reference model, stream order
  logic [31:0]                 lo_half;
  logic [31:0]                 sample;
  logic                        have;             // Sample offered but not yet taken
  logic [`RW_ID_WIDTH-1:0]     aw_id_q;
  logic                        err_seen;
  logic                        saw_stall;
  int                          sent;
  int                          aw_count;
  int                          w_count;
  int                          b_count;
  int                          max_out;
  int                          cycle;
  int                          errors;
  int                          checks;

  axis_ram_writer_top UUT
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axi_aw      (m_axi_aw),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_w       (m_axi_w),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_b       (m_axi_b),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready),
    .status        (status)
  );

  axi_mem_slave u_slave
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .hold_w  (hold_w),
    .aw      (m_axi_aw),
    .awvalid (m_axi_awvalid),
    .awready (m_axi_awready),
    .w       (m_axi_w),
    .wvalid  (m_axi_wvalid),
    .wready  (m_axi_wready),
    .b       (m_axi_b),
    .bvalid  (m_axi_bvalid),
    .bready  (m_axi_bready)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {rng_state[15:0], rng_state[31:16]};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  initial
  begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  always @(posedge aclk)
  begin
    cycle  <= cycle + 1;
    hold_w <= (cycle >= HOLD_START) && (cycle < HOLD_END);
    if (cycle >= MAX_CYCLES)
    begin
      $display("ERROR: timeout after %0d cycles, %0d of %0d bursts answered",
               cycle, b_count, NUM_BURSTS);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Values at the falling edge are the ones the next rising edge acts on
  always @(negedge aclk)
  begin
    if (aresetn)
    begin
      check_value("status.bursts_issued", aw_count, status.bursts_issued);
      check_value("status.bursts_done", b_count, status.bursts_done);
      check_value("status.outstanding", aw_count - b_count, status.outstanding);
      check_value("status.error", err_seen, status.error);
      check_value("m_axi_bready", 1, m_axi_bready);
      if (hold_w && !s_axis_tready)
      begin
        saw_stall = 1'b1;
      end
      if (m_axi_awvalid && m_axi_awready)
      begin
        check_value("m_axi_aw.len", 15, m_axi_aw.len);
        check_value("m_axi_aw.size", 3, m_axi_aw.size);
        check_value("m_axi_aw.burst", 1, m_axi_aw.burst);   // INCR
        check_value("m_axi_aw.cache", 4'b0001, m_axi_aw.cache);   // Bufferable
        check_value("m_axi_aw.addr",
                    `RW_ADDR_BASE + 32'(`RW_BURST_BEATS * 8 * (aw_count % BURSTS_PER_WIN)),
                    m_axi_aw.addr);
        check_value("m_axi_aw.id", aw_count % ID_MOD, m_axi_aw.id);
        aw_id_q = m_axi_aw.id;
        aw_count++;
      end
      if (m_axi_wvalid && m_axi_wready)
      begin
        if (w_count < exp_words.size())
        begin
          check_value("m_axi_w.data", exp_words[w_count], m_axi_w.data);
        end
        else
        begin
          errors++;
          $display("ERROR at %0t ns: W beat %0d has no accepted sample pair", $time, w_count);
        end
        check_value("m_axi_w.last", (w_count % `RW_BURST_BEATS) == `RW_BURST_BEATS - 1,
                    m_axi_w.last);
        check_value("m_axi_w.strb", 8'hFF, m_axi_w.strb);
        check_value("m_axi_w.id", aw_id_q, m_axi_w.id);
        w_count++;
      end
      if (m_axi_bvalid && m_axi_bready)
      begin
        if (m_axi_b.resp != axi_wr_pkg::RESP_OKAY)
        begin
          err_seen = 1'b1;                       // Status follows at the next edge
        end
        b_count++;
      end
      if (aw_count - b_count > `RW_MAX_OUTSTANDING)
      begin
        errors++;
        $display("ERROR at %0t ns: %0d bursts outstanding, above the limit of %0d",
                 $time, aw_count - b_count, `RW_MAX_OUTSTANDING);
      end
      if (aw_count - b_count > max_out)
      begin
        max_out = aw_count - b_count;
      end
    end
  end

  initial
  begin
    aresetn       = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    hold_w        = 1'b0;
    rng_state     = 32'd46;
    have          = 1'b0;
    sample        = '0;
    err_seen      = 1'b0;
    saw_stall     = 1'b0;
    aw_id_q       = '0;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;

    while (sent < NUM_SAMPLES)
    begin
      @(posedge aclk);
      if (!have && (next_rand() % 4) != 0)      // Roughly one idle cycle in four
      begin
        sample = next_rand();
        have   = 1'b1;
      end
      s_axis_tvalid <= have;
      s_axis_tdata  <= sample;
      @(negedge aclk);
      if (s_axis_tvalid && s_axis_tready)
      begin
        if (sent % 2 == 0)
        begin
          lo_half = s_axis_tdata;
        end
        else
        begin
          exp_words.push_back({s_axis_tdata, lo_half});
        end
        sent++;
        have = 1'b0;
      end
    end
    @(posedge aclk);
    s_axis_tvalid <= 1'b0;

    while (b_count < NUM_BURSTS)
    begin
      @(posedge aclk);
    end
    repeat (4) @(posedge aclk);

    check_value("W beats", NUM_BURSTS * `RW_BURST_BEATS, w_count);
    check_value("peak outstanding", `RW_MAX_OUTSTANDING, max_out);
    check_value("status.error", 1, status.error);
    if (!saw_stall)
    begin
      errors++;
      $display("ERROR: s_axis_tready never fell during the long wready stall");
    end
    // Latest pass over each address wins
    for (int k = exp_words.size() - WIN_WORDS; k < exp_words.size(); k++)
    begin
      check_value($sformatf("mem[%0d]", k % WIN_WORDS), exp_words[k],
                  u_slave.mem[k % WIN_WORDS]);
    end

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
source/axi_wr_pkg.sv
source/stream_pkg.sv
source/sample_packer.sv
source/beat_fifo.sv
source/burst_writer.sv
source/write_response_tracker.sv
source/axis_ram_writer_top.sv
verif/axi_mem_slave.sv
verif/tb_axis_ram_writer.sv

/* Bender.yml */
package:
  name: axis_ram_writer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/axi_wr_pkg.sv
      - source/stream_pkg.sv
      - source/sample_packer.sv
      - source/beat_fifo.sv
      - source/burst_writer.sv
      - source/write_response_tracker.sv
      - source/axis_ram_writer_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/axi_mem_slave.sv
      - verif/tb_axis_ram_writer.sv
